// ==== led_badge_top.f ====
hdl/bus_pkg.sv
hdl/display_pkg.sv
hdl/bus_arbiter.sv
hdl/frame_memory.sv
hdl/pattern_writer.sv
hdl/matrix_scanner.sv
hdl/volume_meter.sv
hdl/led_badge_top.sv
tests/led_badge_sva.sv
tests/led_badge_tb.sv

// ==== Bender.yml ====
package:
  name: led_badge

sources:
  - hdl/bus_pkg.sv
  - hdl/display_pkg.sv
  - hdl/bus_arbiter.sv
  - hdl/frame_memory.sv
  - hdl/pattern_writer.sv
  - hdl/matrix_scanner.sv
  - hdl/volume_meter.sv
  - hdl/led_badge_top.sv
  - target: test
    files:
      - tests/led_badge_sva.sv
      - tests/led_badge_tb.sv

// ==== tests/led_badge_tb.sv ====
`timescale 1ns/1ns

module led_badge_tb;

  import display_pkg::*;

  typedef enum {SILENT, POSITIVE, NEGATIVE} stim_mode_t;

  // frame is ~600 clocks, longer while the writer holds the bus
  localparam int FRAME_TIMEOUT = 2000;
  localparam int LEVEL_TIMEOUT = 2 * UPDATE_CYCLES + 100;
  // bar heights for the two sample bands
  localparam level_t LEVEL_MID  = 4'd6;
  localparam level_t LEVEL_FULL = 4'd10;

  logic          clk;
  logic          rst_n_i;
  sample_t       sample_i;
  logic          sample_valid_i;
  matrix_drive_t matrix_o;
  logic          frame_complete_o;
  level_t        level_o;

  int         seed;
  stim_mode_t stim_mode;
  int         errors;
  int         timeouts;

  // frame capture
  logic capturing;
  row_t frame_bytes [FRAME_BYTES];
  int   load_col;
  int   exp_bank;
  int   latch_count;
  int   adv_count;
  int   first_count;
  int   order_errors;
  int   oe_errors;

  led_badge_top dut (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .sample_i         (sample_i),
    .sample_valid_i   (sample_valid_i),
    .matrix_o         (matrix_o),
    .frame_complete_o (frame_complete_o),
    .level_o          (level_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // audio stimulus, falling edge
  //////////////////////////////////////////////////

  always @(negedge clk) begin : stim_drive
    int r;
    int mag;
    r = $random(seed);
    case (stim_mode)
      // band 256..511, level 6
      POSITIVE: begin
        mag            = 256 + (r & 255);
        sample_i       <= sample_t'(mag);
        sample_valid_i <= (r[21:20] != 2'b00);
      end
      // band -1024..-2047, level 10
      NEGATIVE: begin
        mag            = 1024 + (r & 1023);
        sample_i       <= sample_t'(-mag);
        sample_valid_i <= (r[21:20] != 2'b00);
      end
      // garbage data, never valid
      default: begin
        sample_i       <= sample_t'(r);
        sample_valid_i <= 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // matrix monitor
  //////////////////////////////////////////////////

  // column counted from col_first and col_advance
  always @(negedge clk) begin : frame_monitor
    int bank;
    bank = -1;
    if (!rst_n_i) begin
      load_col = 0;
    end else begin
      for (int b = 0; b < N_BANKS; b++) begin
        if (matrix_o.latch_row_bank[b]) bank = b;
      end
      if (capturing && bank >= 0) begin
        // one-hot, in bank order, rows dark
        if ($countones(matrix_o.latch_row_bank) != 1 || bank != exp_bank) order_errors++;
        if (!matrix_o.row_oe_n) oe_errors++;
        frame_bytes[load_col * N_BANKS + bank] = matrix_o.row_data;
        exp_bank++;
        latch_count++;
      end
      if (matrix_o.col_advance) begin
        if (capturing) begin
          if (exp_bank != N_BANKS) order_errors++;
          if (matrix_o.col_first) first_count++;
          adv_count++;
        end
        exp_bank = 0;
        load_col = matrix_o.col_first ? 1 : (load_col + 1) % N_COLS;
      end
    end
  end

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_row(input string name, input row_t exp, input row_t act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s expected %02h actual %02h", name, exp, act);
    end
  endtask

  task automatic check_level(input string name, input level_t exp, input level_t act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_drive(input string name, input matrix_drive_t exp,
                             input matrix_drive_t act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // waits and frame helpers
  //////////////////////////////////////////////////

  // step past a pulse in progress first
  task automatic wait_frame_end(input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (!frame_complete_o && n < FRAME_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!frame_complete_o) begin
      timeouts++;
      $display("%s: no frame end seen within %0d cycles", name, FRAME_TIMEOUT);
    end
  endtask

  task automatic wait_level_change(input string name, input level_t from);
    int n;
    n = 0;
    while (level_o === from && n < LEVEL_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (level_o === from) begin
      timeouts++;
      $display("%s: level stuck at %0d for %0d cycles", name, from, LEVEL_TIMEOUT);
    end
  endtask

  // records one whole frame, frame end to frame end
  task automatic capture_frame(input string name);
    wait_frame_end(name);
    for (int i = 0; i < FRAME_BYTES; i++) frame_bytes[i] = 'x;
    latch_count  = 0;
    adv_count    = 0;
    first_count  = 0;
    order_errors = 0;
    oe_errors    = 0;
    exp_bank     = 0;
    capturing    = 1'b1;
    wait_frame_end(name);
    capturing = 1'b0;
  endtask

  task automatic check_frame(input string name, input level_t lvl);
    row_t exp;
    check_count({name, " latch pulses"}, FRAME_BYTES, latch_count);
    for (int c = 0; c < N_COLS; c++) begin
      // columns below the level lit in every bank
      exp = (c < lvl) ? 8'hff : 8'h00;
      for (int b = 0; b < N_BANKS; b++) begin
        check_row($sformatf("%s col %0d bank %0d", name, c, b), exp,
                  frame_bytes[c * N_BANKS + b]);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic reset_state();
    @(negedge clk);
    check_drive("reset_state matrix", '{row_oe_n: 1'b1, default: '0}, matrix_o);
    check_count("reset_state frame_complete", 0, int'(frame_complete_o));
    check_level("reset_state level", '0, level_o);
  endtask

  task automatic frame_structure();
    capture_frame("frame_structure");
    check_count("frame_structure col_first", 1, first_count);
    check_count("frame_structure column strobes", N_COLS, adv_count);
    check_count("frame_structure latch pulses", FRAME_BYTES, latch_count);
    check_count("frame_structure bank order errors", 0, order_errors);
    check_count("frame_structure oe low while loading", 0, oe_errors);
    // column 15 advanced just before frame end
    check_count("frame_structure column at frame end", 0, load_col);
  endtask

  task automatic silence_frame();
    int lit;
    lit       = 0;
    stim_mode = SILENT;
    // spans at least one window end
    repeat (UPDATE_CYCLES + 20) begin
      @(negedge clk);
      if (level_o !== '0) lit++;
    end
    check_count("silence nonzero level cycles", 0, lit);
    check_level("silence level", '0, level_o);
    capture_frame("silence");
    check_frame("silence", '0);
  endtask

  task automatic positive_amplitude();
    stim_mode = POSITIVE;
    wait_level_change("positive", '0);
    check_level("positive level", LEVEL_MID, level_o);
    // writer latches at this frame end, next frame is mixed
    wait_frame_end("positive");
    capture_frame("positive");
    check_frame("positive", LEVEL_MID);
  endtask

  task automatic negative_amplitude();
    stim_mode = NEGATIVE;
    wait_level_change("negative", LEVEL_MID);
    check_level("negative level", LEVEL_FULL, level_o);
    wait_frame_end("negative");
    capture_frame("negative");
    check_frame("negative", LEVEL_FULL);
  endtask

  task automatic window_clear();
    stim_mode = SILENT;
    // loud tail may keep one more window at 10
    wait_level_change("window_clear", LEVEL_FULL);
    check_level("window_clear level", '0, level_o);
    wait_frame_end("window_clear");
    capture_frame("window_clear");
    check_frame("window_clear", '0);
  endtask

  initial begin
    seed           = 32'h6113_0a79;
    stim_mode      = SILENT;
    errors         = 0;
    timeouts       = 0;
    capturing      = 1'b0;
    load_col       = 0;
    exp_bank       = 0;
    rst_n_i        = 1'b0;
    sample_i       = '0;
    sample_valid_i = 1'b0;
    repeat (3) @(negedge clk);
    rst_n_i = 1'b1;

    reset_state();
    frame_structure();
    silence_frame();
    positive_amplitude();
    negative_amplitude();
    window_clear();

    $display("summary: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== tests/led_badge_sva.sv ====
`timescale 1ns/1ns

module arb_sva (
  input logic             clk,
  input logic             rst_n_i,
  input bus_pkg::wb_req_t scan_req_i,
  input bus_pkg::wb_req_t wr_req_i,
  input bus_pkg::wb_rsp_t scan_rsp_i,
  input bus_pkg::wb_rsp_t wr_rsp_i,
  input bus_pkg::wb_req_t mem_req_i,
  input bus_pkg::wb_rsp_t mem_rsp_i
);

  // master acked inside its still open cycle owns the bus
  logic scan_owns_q;
  logic wr_owns_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      scan_owns_q <= 1'b0;
      wr_owns_q   <= 1'b0;
    end else begin
      scan_owns_q <= scan_req_i.cyc && (scan_owns_q || scan_rsp_i.ack);
      wr_owns_q   <= wr_req_i.cyc && (wr_owns_q || wr_rsp_i.ack);
    end
  end

  //////////////////////////////////////////////////
  // arbitration
  //////////////////////////////////////////////////

  // ack steered to one master only, and one with a live strobe
  ack_to_scanner: assert property (@(posedge clk) disable iff (!rst_n_i)
    scan_rsp_i.ack |-> scan_req_i.stb && !wr_rsp_i.ack)
    else $error("scanner acked without stb or together with writer");

  ack_to_writer: assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_rsp_i.ack |-> wr_req_i.stb && !scan_rsp_i.ack)
    else $error("writer acked without stb or together with scanner");

  // owner keeps the bus while its cyc is up
  grant_hold_scanner: assert property (@(posedge clk) disable iff (!rst_n_i)
    (scan_owns_q && scan_req_i.cyc) |-> mem_req_i == scan_req_i && !wr_rsp_i.ack)
    else $error("scanner lost the bus during its cycle");

  grant_hold_writer: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wr_owns_q && wr_req_i.cyc) |-> mem_req_i == wr_req_i && !scan_rsp_i.ack)
    else $error("writer lost the bus during its cycle");

  //////////////////////////////////////////////////
  // memory side handshake
  //////////////////////////////////////////////////

  // ack only answers a live strobe
  ack_with_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
    mem_rsp_i.ack |-> mem_req_i.stb)
    else $error("memory ack without stb");

  // strobe held until acked
  stb_until_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
    (mem_req_i.stb && !mem_rsp_i.ack) |=> mem_req_i.stb)
    else $error("stb dropped before ack");

endmodule

bind bus_arbiter arb_sva u_arb_sva (
  .clk        (clk),
  .rst_n_i    (rst_n_i),
  .scan_req_i (scan_req_i),
  .wr_req_i   (wr_req_i),
  .scan_rsp_i (scan_rsp_o),
  .wr_rsp_i   (wr_rsp_o),
  .mem_req_i  (mem_req_o),
  .mem_rsp_i  (mem_rsp_i)
);

// ==== hdl/led_badge_top.sv ====
`timescale 1ns/1ns

module led_badge_top (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  display_pkg::sample_t       sample_i,
  input  logic                       sample_valid_i,
  output display_pkg::matrix_drive_t matrix_o,
  output logic                       frame_complete_o,
  output display_pkg::level_t        level_o
);

  import bus_pkg::*;

  // per-master bus links
  wb_req_t scan_req;
  wb_rsp_t scan_rsp;
  wb_req_t wr_req;
  wb_rsp_t wr_rsp;
  // arbiter to memory
  wb_req_t mem_req;
  wb_rsp_t mem_rsp;

  //////////////////////////////////////////////////
  // bus masters
  //////////////////////////////////////////////////

  matrix_scanner u_scanner (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .bus_req_o        (scan_req),
    .bus_rsp_i        (scan_rsp),
    .drive_o          (matrix_o),
    .frame_complete_o (frame_complete_o)
  );

  // redraw triggered by the scanner's frame end
  pattern_writer u_writer (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .level_i          (level_o),
    .frame_complete_i (frame_complete_o),
    .bus_req_o        (wr_req),
    .bus_rsp_i        (wr_rsp)
  );

  //////////////////////////////////////////////////
  // shared bus and audio path
  //////////////////////////////////////////////////

  bus_arbiter u_arbiter (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .scan_req_i (scan_req),
    .wr_req_i   (wr_req),
    .scan_rsp_o (scan_rsp),
    .wr_rsp_o   (wr_rsp),
    .mem_req_o  (mem_req),
    .mem_rsp_i  (mem_rsp)
  );

  frame_memory u_memory (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (mem_req),
    .rsp_o   (mem_rsp)
  );

  volume_meter u_meter (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .level_o        (level_o)
  );

endmodule

// ==== hdl/volume_meter.sv ====
`timescale 1ns/1ns

module volume_meter (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  display_pkg::sample_t sample_i,
  input  logic                 sample_valid_i,
  output display_pkg::level_t  level_o
);

  import display_pkg::*;

  logic [$bits(sample_t)-1:0] magnitude;
  logic [$bits(sample_t)-1:0] peak_q;
  logic [$bits(sample_t)-1:0] peak_next;
  logic [WINDOW_W-1:0]        window_q;
  level_t                     level_q;

  // level from highest set bit of the peak
  function automatic level_t bucket(input logic [$bits(sample_t)-1:0] p);
    level_t lvl;
    if (p[11] || p[10]) lvl = level_t'(MAX_LEVEL);
    else if (p[9])      lvl = 4'd8;
    else if (p[8])      lvl = 4'd6;
    else if (p[7])      lvl = 4'd4;
    else if (p[6])      lvl = 4'd3;
    else if (p[5])      lvl = 4'd2;
    else if (p[4])      lvl = 4'd1;
    else                lvl = 4'd0;
    return lvl;
  endfunction

  // abs value, -2048 maps to 12'h800
  assign magnitude = sample_i[$bits(sample_t)-1] ? $unsigned(-sample_i) : $unsigned(sample_i);
  // running max including this cycle's sample
  assign peak_next = (sample_valid_i && (magnitude > peak_q)) ? magnitude : peak_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      peak_q   <= '0;
      window_q <= WINDOW_W'(UPDATE_CYCLES - 1);
      level_q  <= '0;
    end else if (window_q == '0) begin
      // window end, publish and restart
      level_q  <= bucket(peak_next);
      peak_q   <= '0;
      window_q <= WINDOW_W'(UPDATE_CYCLES - 1);
    end else begin
      peak_q   <= peak_next;
      window_q <= window_q - 1'b1;
    end
  end

  assign level_o = level_q;

endmodule

// ==== hdl/matrix_scanner.sv ====
`timescale 1ns/1ns

module matrix_scanner (
  input  logic                       clk,
  input  logic                       rst_n_i,
  output bus_pkg::wb_req_t           bus_req_o,
  input  bus_pkg::wb_rsp_t           bus_rsp_i,
  output display_pkg::matrix_drive_t drive_o,
  output logic                       frame_complete_o
);

  import bus_pkg::*;
  import display_pkg::*;

  typedef enum logic [2:0] {
    S_START,
    S_WAIT,
    S_LATCH,
    S_ADVANCE,
    S_DWELL
  } state_t;

  state_t             state_q;
  logic [COL_W-1:0]   col_q;
  logic [BANK_W-1:0]  bank_q;
  logic [DWELL_W-1:0] dwell_q;
  wb_req_t            req_q;
  matrix_drive_t      drive_q;
  logic               done_q;

  logic               last_bank;
  logic               last_col;

  assign last_bank = (bank_q == BANK_W'(N_BANKS - 1));
  assign last_col  = (col_q == COL_W'(N_COLS - 1));

  // byte for column c, bank b
  function automatic logic [ADDR_W-1:0] frame_adr(
    input logic [COL_W-1:0]  col,
    input logic [BANK_W-1:0] bank
  );
    return FRAME_BASE + ADDR_W'(col) * ADDR_W'(N_BANKS) + ADDR_W'(bank);
  endfunction

  //////////////////////////////////////////////////
  // column sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= S_START;
      col_q   <= '0;
      bank_q  <= '0;
      dwell_q <= '0;
      req_q   <= '0;
      drive_q <= '{row_oe_n: 1'b1, default: '0};
      done_q  <= 1'b0;
    end else begin
      // frame_complete is a single pulse
      done_q <= 1'b0;
      case (state_q)
        // open the column burst at bank 0
        S_START: begin
          req_q.cyc <= 1'b1;
          req_q.stb <= 1'b1;
          req_q.we  <= 1'b0;
          req_q.adr <= frame_adr(col_q, '0);
          req_q.dat <= '0;
          state_q   <= S_WAIT;
        end
        // cyc stays up until the last bank
        S_WAIT: begin
          if (bus_rsp_i.ack) begin
            req_q.stb                      <= 1'b0;
            req_q.cyc                      <= !last_bank;
            drive_q.latch_row_bank[bank_q] <= 1'b1;
            drive_q.row_data               <= bus_rsp_i.dat;
            state_q                        <= S_LATCH;
          end
        end
        // latch pulse out, stb low this cycle
        S_LATCH: begin
          drive_q.latch_row_bank <= '0;
          if (last_bank) begin
            drive_q.col_advance <= 1'b1;
            drive_q.col_first   <= (col_q == '0);
            state_q             <= S_ADVANCE;
          end else begin
            bank_q    <= bank_q + 1'b1;
            req_q.stb <= 1'b1;
            req_q.adr <= frame_adr(col_q, bank_q + 1'b1);
            state_q   <= S_WAIT;
          end
        end
        // shift column, then light it
        S_ADVANCE: begin
          drive_q.col_advance <= 1'b0;
          drive_q.col_first   <= 1'b0;
          drive_q.row_oe_n    <= 1'b0;
          dwell_q             <= DWELL_W'(DWELL_CYCLES - 1);
          state_q             <= S_DWELL;
        end
        // oe low for DWELL_CYCLES
        S_DWELL: begin
          if (dwell_q == '0) begin
            drive_q.row_oe_n <= 1'b1;
            bank_q           <= '0;
            col_q            <= last_col ? '0 : col_q + 1'b1;
            done_q           <= last_col;
            state_q          <= S_START;
          end else begin
            dwell_q <= dwell_q - 1'b1;
          end
        end
        default: state_q <= S_START;
      endcase
    end
  end

  assign bus_req_o        = req_q;
  assign drive_o          = drive_q;
  assign frame_complete_o = done_q;

endmodule

// ==== hdl/pattern_writer.sv ====
`timescale 1ns/1ns

module pattern_writer (
  input  logic                clk,
  input  logic                rst_n_i,
  input  display_pkg::level_t level_i,
  input  logic                frame_complete_i,
  output bus_pkg::wb_req_t    bus_req_o,
  input  bus_pkg::wb_rsp_t    bus_rsp_i
);

  import bus_pkg::*;
  import display_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ISSUE,
    S_WAIT
  } state_t;

  state_t            state_q;
  // first redraw straight out of reset
  logic              boot_q;
  level_t            level_q;
  logic [BYTE_W-1:0] byte_q;
  wb_req_t           req_q;

  logic [COL_W-1:0]  byte_col;
  logic              last_byte;

  // byte address is col * N_BANKS + bank
  assign byte_col  = COL_W'(byte_q / N_BANKS);
  assign last_byte = (byte_q == BYTE_W'(FRAME_BYTES - 1));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      boot_q  <= 1'b1;
      byte_q  <= '0;
      req_q   <= '0;
    end else begin
      case (state_q)
        // frame_complete only looked at here
        S_IDLE: begin
          if (boot_q || frame_complete_i) begin
            boot_q  <= 1'b0;
            level_q <= level_i;
            byte_q  <= '0;
            state_q <= S_ISSUE;
          end
        end
        // column below level lit in all banks
        S_ISSUE: begin
          req_q.cyc <= 1'b1;
          req_q.stb <= 1'b1;
          req_q.we  <= 1'b1;
          req_q.adr <= FRAME_BASE + ADDR_W'(byte_q);
          req_q.dat <= {DATA_W{byte_col < level_q}};
          state_q   <= S_WAIT;
        end
        S_WAIT: begin
          if (bus_rsp_i.ack) begin
            req_q.stb <= 1'b0;
            if (last_byte) begin
              // burst done, release bus
              req_q.cyc <= 1'b0;
              req_q.we  <= 1'b0;
              state_q   <= S_IDLE;
            end else begin
              byte_q  <= byte_q + 1'b1;
              state_q <= S_ISSUE;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign bus_req_o = req_q;

endmodule

// ==== hdl/frame_memory.sv ====
`timescale 1ns/1ns

module frame_memory (
  input  logic             clk,
  input  logic             rst_n_i,
  input  bus_pkg::wb_req_t req_i,
  output bus_pkg::wb_rsp_t rsp_o
);

  import bus_pkg::*;
  import display_pkg::*;

  // frame store, one byte per bank per column
  logic [DATA_W-1:0] mem_q [FRAME_BYTES];

  logic [ADDR_W-1:0] offset;
  logic [BYTE_W-1:0] index;
  logic              hit;
  logic              access;

  logic              ack_q;
  logic [DATA_W-1:0] dat_q;

  // decode relative to frame base
  assign offset = req_i.adr - FRAME_BASE;
  assign index  = offset[BYTE_W-1:0];
  assign hit    = (req_i.adr >= FRAME_BASE) && (offset < ADDR_W'(FRAME_BYTES));

  // stb still high in the ack cycle, so skip it
  // one beat per strobe
  assign access = req_i.cyc && req_i.stb && !ack_q;

  // ack one cycle after the strobe
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // write, and read data registered with ack
  // out of range reads zero, writes dropped
  always_ff @(posedge clk) begin
    if (access && req_i.we && hit) begin
      mem_q[index] <= req_i.dat;
    end
    if (access) begin
      dat_q <= hit ? mem_q[index] : '0;
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = dat_q;

endmodule

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter (
  input  logic             clk,
  input  logic             rst_n_i,
  input  bus_pkg::wb_req_t scan_req_i,
  input  bus_pkg::wb_req_t wr_req_i,
  output bus_pkg::wb_rsp_t scan_rsp_o,
  output bus_pkg::wb_rsp_t wr_rsp_o,
  output bus_pkg::wb_req_t mem_req_o,
  input  bus_pkg::wb_rsp_t mem_rsp_i
);

  import bus_pkg::*;

  grant_t grant_q;

  //////////////////////////////////////////////////
  // grant register
  //////////////////////////////////////////////////

  // new grant only from idle, scanner first
  // grant held until owner drops cyc
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      grant_q <= GRANT_NONE;
    end else begin
      case (grant_q)
        GRANT_NONE: begin
          if (scan_req_i.cyc) begin
            grant_q <= GRANT_SCANNER;
          end else if (wr_req_i.cyc) begin
            grant_q <= GRANT_WRITER;
          end
        end
        GRANT_SCANNER: begin
          if (!scan_req_i.cyc) begin
            grant_q <= GRANT_NONE;
          end
        end
        GRANT_WRITER: begin
          if (!wr_req_i.cyc) begin
            grant_q <= GRANT_NONE;
          end
        end
        default: grant_q <= GRANT_NONE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // request mux and response steering
  //////////////////////////////////////////////////

  // idle bus drives nothing
  always_comb begin
    mem_req_o  = '0;
    scan_rsp_o = '0;
    wr_rsp_o   = '0;
    case (grant_q)
      GRANT_SCANNER: begin
        mem_req_o  = scan_req_i;
        scan_rsp_o = mem_rsp_i;
      end
      GRANT_WRITER: begin
        mem_req_o = wr_req_i;
        wr_rsp_o  = mem_rsp_i;
      end
      default: ;
    endcase
  end

endmodule

// ==== hdl/display_pkg.sv ====
package display_pkg;

  //////////////////////////////////////////////////
  // matrix geometry
  //////////////////////////////////////////////////

  localparam int N_COLS      = 16;
  // 8-row banks per column
  localparam int N_BANKS     = 4;
  // one byte per bank per column
  localparam int FRAME_BYTES = N_COLS * N_BANKS;

  // counter widths
  localparam int COL_W  = $clog2(N_COLS);
  localparam int BANK_W = $clog2(N_BANKS);
  localparam int BYTE_W = $clog2(FRAME_BYTES);

  //////////////////////////////////////////////////
  // timing
  //////////////////////////////////////////////////

  // column on-time in clocks
  localparam int DWELL_CYCLES  = 16;
  localparam int DWELL_W       = $clog2(DWELL_CYCLES);
  // volume peak window in clocks
  localparam int UPDATE_CYCLES = 2000;
  localparam int WINDOW_W      = $clog2(UPDATE_CYCLES);

  // full scale of the bar graph
  localparam int MAX_LEVEL = 10;

  typedef logic [7:0]         row_t;
  typedef logic [3:0]         level_t;
  typedef logic signed [11:0] sample_t;

  // pins toward the row/column drivers
  typedef struct packed {
    logic               row_oe_n;
    logic [N_BANKS-1:0] latch_row_bank;
    row_t               row_data;
    logic               col_first;
    logic               col_advance;
  } matrix_drive_t;

endpackage

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

  //////////////////////////////////////////////////
  // bus widths and address map
  //////////////////////////////////////////////////

  // single-beat byte bus
  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  // start of the frame store window
  localparam logic [ADDR_W-1:0] FRAME_BASE = 16'h0400;

  //////////////////////////////////////////////////
  // wishbone classic cycle
  //////////////////////////////////////////////////

  // master to slave
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    // write data, don't care on reads
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  // slave to master, dat valid with ack
  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

  // current bus owner
  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_SCANNER,
    GRANT_WRITER
  } grant_t;

endpackage
